/* hdl/ex_pkg.sv */
//////////////////////////////////////////////////
// Shared widths and encodings for the execute stage
// The multiplier width is fixed at XLEN, and MUL_STEPS must divide XLEN
// Operator words are decoded as ALU or MUL by the unit select
//////////////////////////////////////////////////

package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data word
  localparam int XLEN       = 32;
  // Register file address
  localparam int REG_ADDR_W = 5;
  // Operator field shared by both units
  localparam int OPER_W     = 4;
  // Shift amount, log2 of the word
  localparam int SHAMT_W    = $clog2(XLEN);

  // Multiplier iterations, each consumes one chunk of operand b
  localparam int MUL_STEPS  = 4;
  localparam int MUL_CHUNK  = XLEN / MUL_STEPS;
  localparam int MUL_CNT_W  = $clog2(MUL_STEPS);

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Functional unit select
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  // ALU operators, upper half holds slt and the branch compares
  typedef enum logic [OPER_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_BEQ  = 4'ha,
    ALU_BNE  = 4'hb,
    ALU_BLT  = 4'hc,
    ALU_BGE  = 4'hd,
    ALU_BLTU = 4'he,
    ALU_BGEU = 4'hf
  } alu_op_e;

  // Multiplier operators; HSS/HSU/HUU give the upper word
  typedef enum logic [OPER_W-1:0] {
    MUL_LO  = 4'h0,
    MUL_HSS = 4'h1,
    MUL_HSU = 4'h2,
    MUL_HUU = 4'h3
  } mul_op_e;

  // One operator word, two views
  typedef union packed {
    alu_op_e alu;
    mul_op_e mul;
  } ex_operator_u;

endpackage

/* hdl/ex_mul_if.sv */
//////////////////////////////////////////////////
// Issue and result handshake to the multiplier
// Result is held by the unit until downstream_ready
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface ex_mul_if import ex_pkg::*; ();

  // Issue side
  logic            start;
  logic            kill;
  mul_op_e         op;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            downstream_ready;

  // Unit side
  logic            ready;
  logic            done;
  logic [XLEN-1:0] result;

  // Stage sequencer
  modport seq (
    output start, kill, op, op_a, op_b, downstream_ready,
    input  ready, done, result
  );

  // Multiplier
  modport unit (
    input  start, kill, op, op_a, op_b, downstream_ready,
    output ready, done, result
  );

endinterface

/* hdl/ex_alu.sv */
//////////////////////////////////////////////////
// Single-cycle ALU and branch comparator
// Shift amount is taken from op_b[4:0]
// cmp_o is only meaningful for slt and branch ops
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o
);

  // Shared 33-bit adder
  logic            sub_en;
  logic            signed_cmp;
  logic [XLEN:0]   adder_a;
  logic [XLEN:0]   adder_b;
  logic [XLEN:0]   adder_res;
  logic            is_lt;
  logic            is_eq;

  // Shifter
  logic [XLEN-1:0]        shift_in;
  logic signed [XLEN:0]   shift_ext;
  logic signed [XLEN:0]   shift_res;
  logic [XLEN-1:0]        shift_right;
  logic [XLEN-1:0]        shift_left;
  logic [SHAMT_W-1:0]     shamt;

  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] d);
    logic [XLEN-1:0] r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = d[XLEN-1-i];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Adder / comparator
  //////////////////////////////////////////////////

  // Everything but add runs the adder as a subtractor
  assign sub_en     = (op_i != ALU_ADD);
  assign signed_cmp = (op_i == ALU_SLT) || (op_i == ALU_BLT) || (op_i == ALU_BGE);

  // Extra top bit makes the borrow a true less-than for both signednesses
  assign adder_a   = {signed_cmp & op_a_i[XLEN-1], op_a_i};
  assign adder_b   = sub_en ? ~{signed_cmp & op_b_i[XLEN-1], op_b_i}
                            : {1'b0, op_b_i};
  assign adder_res = adder_a + adder_b + {{XLEN{1'b0}}, sub_en};

  assign is_lt = adder_res[XLEN];
  // Zero difference means equal
  assign is_eq = (adder_res[XLEN-1:0] == '0);

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  assign shamt = op_b_i[SHAMT_W-1:0];

  // sll reuses the right shifter on reversed data
  assign shift_in    = (op_i == ALU_SLL) ? bit_rev(op_a_i) : op_a_i;
  assign shift_ext   = {(op_i == ALU_SRA) & shift_in[XLEN-1], shift_in};
  assign shift_res   = shift_ext >>> shamt;
  assign shift_right = shift_res[XLEN-1:0];
  assign shift_left  = bit_rev(shift_right);

  // Branch condition or slt bit
  always_comb begin
    unique case (op_i)
      ALU_BEQ:                    cmp_o = is_eq;
      ALU_BNE:                    cmp_o = !is_eq;
      ALU_SLT, ALU_SLTU,
      ALU_BLT, ALU_BLTU:          cmp_o = is_lt;
      ALU_BGE, ALU_BGEU:          cmp_o = !is_lt;
      default:                    cmp_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    unique case (op_i)
      ALU_ADD, ALU_SUB:   result_o = adder_res[XLEN-1:0];
      ALU_AND:            result_o = op_a_i & op_b_i;
      ALU_OR:             result_o = op_a_i | op_b_i;
      ALU_XOR:            result_o = op_a_i ^ op_b_i;
      ALU_SLL:            result_o = shift_left;
      ALU_SRL, ALU_SRA:   result_o = shift_right;
      // slt family and compares return the flag in bit 0
      default:            result_o = {{(XLEN-1){1'b0}}, cmp_o};
    endcase
  end

endmodule

/* hdl/ex_mult.sv */
//////////////////////////////////////////////////
// Iterative 32x32 multiplier, MUL_STEPS cycles per op
// First step runs on the issue edge from the bus operands
// Result is held until downstream_ready; kill drops it
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  ex_mul_if.unit bus
);

  // Control state
  logic                  busy_q;
  logic                  done_q;
  logic [MUL_CNT_W-1:0]  cnt_q;

  // Latched operands
  logic [XLEN:0]         a_q;
  logic [XLEN-1:0]       b_q;
  logic                  b_sgn_q;
  mul_op_e               op_q;
  logic [2*XLEN+1:0]     acc_q;

  logic                  idle;
  logic                  start_en;
  logic                  step_en;
  logic                  last_step;
  logic                  a_sgn;
  logic [XLEN:0]         a_ext;
  logic [XLEN:0]         mul_a;
  logic [MUL_CHUNK-1:0]  chunk;
  logic [MUL_CHUNK:0]    chunk_ext;
  logic [MUL_CNT_W-1:0]  step;
  logic signed [2*XLEN+1:0] pp;
  logic [2*XLEN+1:0]     acc_next;

  assign idle      = !busy_q && !done_q;
  assign start_en  = bus.start && idle && !bus.kill;
  assign step_en   = start_en || busy_q;
  assign last_step = busy_q && (cnt_q == MUL_CNT_W'(MUL_STEPS - 1));

  // Operand a is signed for mulh and mulhsu
  assign a_sgn = (bus.op == MUL_HSS) || (bus.op == MUL_HSU);
  assign a_ext = {a_sgn & bus.op_a[XLEN-1], bus.op_a};

  //////////////////////////////////////////////////
  // Partial product datapath
  //////////////////////////////////////////////////

  // Issue cycle uses bus inputs, later steps use latched copies
  assign mul_a = busy_q ? a_q : a_ext;
  assign chunk = busy_q ? b_q[MUL_CHUNK-1:0] : bus.op_b[MUL_CHUNK-1:0];
  assign step  = busy_q ? cnt_q : '0;

  // Top chunk of a signed b carries the negative weight
  assign chunk_ext = {last_step & b_sgn_q & chunk[MUL_CHUNK-1], chunk};

  // 33 x 9 signed product, sign-extended to the accumulator
  assign pp = $signed(mul_a) * $signed(chunk_ext);

  assign acc_next = (busy_q ? acc_q : '0) + (pp << (MUL_CHUNK * step));

  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (bus.kill) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_en) begin
      // Step 0 completes on this edge
      busy_q <= 1'b1;
      cnt_q  <= MUL_CNT_W'(1);
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_step) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (done_q && bus.downstream_ready) begin
      // Result handed over
      done_q <= 1'b0;
    end
  end

  // Operand latch and accumulator
  always_ff @(posedge clk) begin
    if (start_en) begin
      a_q     <= a_ext;
      b_q     <= bus.op_b >> MUL_CHUNK;
      b_sgn_q <= (bus.op == MUL_HSS);
      op_q    <= bus.op;
    end else if (busy_q) begin
      b_q <= b_q >> MUL_CHUNK;
    end
    if (step_en) begin
      acc_q <= acc_next;
    end
  end

  // Low word for mul, high word otherwise
  assign bus.result = (op_q == MUL_LO) ? acc_q[XLEN-1:0] : acc_q[2*XLEN-1:XLEN];
  assign bus.done   = done_q;
  assign bus.ready  = idle || (done_q && bus.downstream_ready);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // done only follows an issue MUL_STEPS cycles back
  a_done_after_start: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(bus.done) |-> $past(bus.start, MUL_STEPS)
  );

  // Held result under back-pressure
  a_result_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus.done && !bus.downstream_ready && !bus.kill) |=> (bus.done && $stable(bus.result))
  );

endmodule

/* hdl/ex_wb_pipe.sv */
//////////////////////////////////////////////////
// Stage handshake, write-data mux and EX/WB register
// A multiply holds EX until the multiplier reports done
// Branch compares never write the register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_wb_pipe import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // From decode
  input  logic                  in_valid_i,
  input  logic                  kill_i,
  input  unit_e                 in_unit_i,
  input  ex_operator_u          in_oper_i,
  input  logic [XLEN-1:0]       in_op_a_i,
  input  logic [XLEN-1:0]       in_op_b_i,
  input  logic [REG_ADDR_W-1:0] in_rd_i,
  input  logic                  in_rf_we_i,

  // From the ALU
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic                  alu_cmp_i,

  // Multiplier handshake
  ex_mul_if.seq                 mul,

  // Upstream ready
  output logic                  in_ready_o,

  // EX/WB record
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  out_rf_we_o,
  output logic [REG_ADDR_W-1:0] out_rd_o,
  output logic [XLEN-1:0]       out_wdata_o,
  output logic                  out_bch_taken_o
);

  logic            instr_valid;
  logic            wb_ready;
  logic            is_mul;
  logic            is_branch;
  logic            ex_valid;
  logic [XLEN-1:0] wdata;

  // Kill drops whatever is presented
  assign instr_valid = in_valid_i && !kill_i;
  assign wb_ready    = out_ready_i || !out_valid_o;

  assign is_mul    = (in_unit_i == UNIT_MUL);
  assign is_branch = !is_mul && (in_oper_i.alu inside {ALU_BEQ, ALU_BNE, ALU_BLT,
                                                       ALU_BGE, ALU_BLTU, ALU_BGEU});

  //////////////////////////////////////////////////
  // Multiplier issue
  //////////////////////////////////////////////////

  assign mul.start            = instr_valid && is_mul;
  assign mul.kill             = kill_i;
  assign mul.op               = in_oper_i.mul;
  assign mul.op_a             = in_op_a_i;
  assign mul.op_b             = in_op_b_i;
  assign mul.downstream_ready = wb_ready;

  // ALU always valid; a multiply waits for done
  assign ex_valid   = instr_valid && (!is_mul || mul.done);
  assign in_ready_o = kill_i || (wb_ready && mul.ready && (!is_mul || mul.done));

  // Write data by unit
  assign wdata = is_mul ? mul.result : alu_result_i;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o     <= 1'b0;
      out_rf_we_o     <= 1'b0;
      out_bch_taken_o <= 1'b0;
    end else if (ex_valid && wb_ready) begin
      out_valid_o     <= 1'b1;
      out_rf_we_o     <= in_rf_we_i && !is_branch;
      out_bch_taken_o <= is_branch && alu_cmp_i;
    end else if (wb_ready) begin
      // Nothing to pass on, insert a bubble
      out_valid_o     <= 1'b0;
      out_rf_we_o     <= 1'b0;
      out_bch_taken_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (ex_valid && wb_ready) begin
      out_rd_o    <= in_rd_i;
      out_wdata_o <= wdata;
    end
  end

  // Record holds while WB stalls
  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable({out_rd_o, out_wdata_o, out_rf_we_o, out_bch_taken_o}))
  );

endmodule

/* hdl/ex_stage_top.sv */
//////////////////////////////////////////////////
// Execute stage top, ready/valid on both sides
// Operator word is decoded by in_unit_i
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_top import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // Decode side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  kill_i,
  input  unit_e                 in_unit_i,
  input  logic [OPER_W-1:0]     in_oper_i,
  input  logic [XLEN-1:0]       in_op_a_i,
  input  logic [XLEN-1:0]       in_op_b_i,
  input  logic [REG_ADDR_W-1:0] in_rd_i,
  input  logic                  in_rf_we_i,

  // Write-back side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  out_rf_we_o,
  output logic [REG_ADDR_W-1:0] out_rd_o,
  output logic [XLEN-1:0]       out_wdata_o,
  output logic                  out_bch_taken_o
);

  ex_operator_u    oper;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;

  ex_mul_if mul_bus ();

  // Same bits, viewed through the union
  assign oper = in_oper_i;

  // ALU
  ex_alu u_alu (
    .op_i     (oper.alu),
    .op_a_i   (in_op_a_i),
    .op_b_i   (in_op_b_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  // Multiplier
  ex_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (mul_bus.unit)
  );

  // Handshake and EX/WB register
  ex_wb_pipe u_pipe (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .kill_i          (kill_i),
    .in_unit_i       (in_unit_i),
    .in_oper_i       (oper),
    .in_op_a_i       (in_op_a_i),
    .in_op_b_i       (in_op_b_i),
    .in_rd_i         (in_rd_i),
    .in_rf_we_i      (in_rf_we_i),
    .alu_result_i    (alu_result),
    .alu_cmp_i       (alu_cmp),
    .mul             (mul_bus.seq),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_rf_we_o     (out_rf_we_o),
    .out_rd_o        (out_rd_o),
    .out_wdata_o     (out_wdata_o),
    .out_bch_taken_o (out_bch_taken_o)
  );

endmodule

/* verif/ex_stage_tb.sv */
//////////////////////////////////////////////////
// Execute stage testbench driven by verif/ex_patterns.hex
// Pass 0 holds out_ready_i high, pass 1 stalls WB at random
// Killed rows must leave no output record
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  // Pattern file layout, nine words per row
  localparam int N_PATS    = 24;
  localparam int PAT_COLS  = 9;
  localparam int MEM_AW    = $clog2(N_PATS * PAT_COLS);
  localparam int COL_UNIT  = 0;
  localparam int COL_OPER  = 1;
  localparam int COL_A     = 2;
  localparam int COL_B     = 3;
  localparam int COL_RD    = 4;
  localparam int COL_WE    = 5;
  localparam int COL_KILL  = 6;
  localparam int COL_WDATA = 7;
  localparam int COL_BCH   = 8;

  localparam int TIMEOUT   = 200;
  // Row of the first multiply, timed in pass 0
  localparam int LAT_IDX   = 16;
  localparam int MUL_LAT   = 5;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  kill_i;
  unit_e                 in_unit_i;
  logic [OPER_W-1:0]     in_oper_i;
  logic [XLEN-1:0]       in_op_a_i;
  logic [XLEN-1:0]       in_op_b_i;
  logic [REG_ADDR_W-1:0] in_rd_i;
  logic                  in_rf_we_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  out_rf_we_o;
  logic [REG_ADDR_W-1:0] out_rd_o;
  logic [XLEN-1:0]       out_wdata_o;
  logic                  out_bch_taken_o;

  logic [31:0] pat_mem [0:N_PATS*PAT_COLS-1];
  // Rows accepted and not killed, oldest first
  int          exp_q[$];
  int          present_cyc[int];
  int          cyc;
  int          errors;
  int          checks;
  logic        timeout_hit;
  logic        drive_done;
  logic        collect_done;
  logic        stall_en;

  ex_stage_top UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .kill_i          (kill_i),
    .in_unit_i       (in_unit_i),
    .in_oper_i       (in_oper_i),
    .in_op_a_i       (in_op_a_i),
    .in_op_b_i       (in_op_b_i),
    .in_rd_i         (in_rd_i),
    .in_rf_we_i      (in_rf_we_i),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_rf_we_o     (out_rf_we_o),
    .out_rd_o        (out_rd_o),
    .out_wdata_o     (out_wdata_o),
    .out_bch_taken_o (out_bch_taken_o)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Cycle count for latency
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] pat_field(input int idx, input int col);
    return pat_mem[MEM_AW'(idx * PAT_COLS + col)];
  endfunction

  // Branch compares never write the register file
  function automatic logic is_branch_op(input int idx);
    logic [31:0] unit_w;
    logic [31:0] oper_w;
    unit_w = pat_field(idx, COL_UNIT);
    oper_w = pat_field(idx, COL_OPER);
    return (unit_w[0] == UNIT_ALU) &&
           (oper_w[OPER_W-1:0] inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU});
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic idle_inputs();
    in_valid_i = 1'b0;
    kill_i     = 1'b0;
    in_unit_i  = UNIT_ALU;
    in_oper_i  = '0;
    in_op_a_i  = '0;
    in_op_b_i  = '0;
    in_rd_i    = '0;
    in_rf_we_i = 1'b0;
  endtask

  task automatic apply_item(input int idx);
    logic [31:0] w;
    in_valid_i = 1'b1;
    w          = pat_field(idx, COL_UNIT);
    in_unit_i  = unit_e'(w[0]);
    w          = pat_field(idx, COL_OPER);
    in_oper_i  = w[OPER_W-1:0];
    in_op_a_i  = pat_field(idx, COL_A);
    in_op_b_i  = pat_field(idx, COL_B);
    w          = pat_field(idx, COL_RD);
    in_rd_i    = w[REG_ADDR_W-1:0];
    w          = pat_field(idx, COL_WE);
    in_rf_we_i = w[0];
    w          = pat_field(idx, COL_KILL);
    kill_i     = w[0];
  endtask

  //////////////////////////////////////////////////
  // Decode side
  //////////////////////////////////////////////////

  // Present one row and hold it until in_ready_o at an edge
  task automatic drive_item(input int idx);
    int          waited;
    logic [31:0] kill_w;
    waited = 0;
    kill_w = pat_field(idx, COL_KILL);
    apply_item(idx);
    present_cyc[idx] = cyc;
    @(negedge clk);
    while (!in_ready_o && !timeout_hit) begin
      waited++;
      if (waited > TIMEOUT) begin
        errors++;
        timeout_hit = 1'b1;
        $display("Timeout: row %0d was not accepted within %0d cycles", idx, TIMEOUT);
      end else begin
        @(negedge clk);
      end
    end
    if (!timeout_hit) begin
      // Killed rows are dropped by the stage
      if (!kill_w[0]) begin
        exp_q.push_back(idx);
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_all();
    for (int i = 0; i < N_PATS; i++) begin
      if (!timeout_hit) begin
        drive_item(i);
      end
    end
    idle_inputs();
    drive_done = 1'b1;
  endtask

  // WB ready, low about 30% of cycles when stalling
  task automatic drive_out_ready();
    while (!collect_done) begin
      @(posedge clk);
      #1;
      if (stall_en) begin
        out_ready_i = (($urandom % 100) >= 30);
      end else begin
        out_ready_i = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Write-back side
  //////////////////////////////////////////////////

  task automatic compare_record(input int idx, input int phase);
    logic [31:0] we_w;
    logic        exp_we;
    we_w   = pat_field(idx, COL_WE);
    exp_we = we_w[0] && !is_branch_op(idx);
    check_value("out_rd_o", 32'(out_rd_o), pat_field(idx, COL_RD));
    check_value("out_rf_we_o", 32'(out_rf_we_o), 32'(exp_we));
    check_value("out_bch_taken_o", 32'(out_bch_taken_o), pat_field(idx, COL_BCH));
    // Write data matters only when the record writes
    if (exp_we) begin
      check_value("out_wdata_o", out_wdata_o, pat_field(idx, COL_WDATA));
    end
    if (phase == 0 && idx == LAT_IDX) begin
      check_value("out_valid_o latency", 32'(cyc - present_cyc[idx]), 32'(MUL_LAT));
    end
  endtask

  // Sample at the falling edge, where all outputs are settled
  task automatic collect_records(input int phase);
    int                    idle_cnt;
    int                    idx;
    logic                  held;
    logic [REG_ADDR_W-1:0] held_rd;
    logic [XLEN-1:0]       held_wdata;
    logic                  held_we;
    logic                  held_bch;
    idle_cnt = 0;
    held     = 1'b0;
    while ((!drive_done || exp_q.size() != 0) && !timeout_hit) begin
      @(negedge clk);
      // Stalled record must not move
      if (held) begin
        check_value("out_valid_o hold", 32'(out_valid_o), 32'd1);
        check_value("out_rd_o hold", 32'(out_rd_o), 32'(held_rd));
        check_value("out_wdata_o hold", out_wdata_o, held_wdata);
        check_value("out_rf_we_o hold", 32'(out_rf_we_o), 32'(held_we));
        check_value("out_bch_taken_o hold", 32'(out_bch_taken_o), 32'(held_bch));
      end
      held = 1'b0;
      if (out_valid_o && out_ready_i) begin
        idle_cnt = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output record at %0t with no accepted instruction left", $time);
        end else begin
          idx = exp_q.pop_front();
          compare_record(idx, phase);
        end
      end else begin
        if (out_valid_o) begin
          held       = 1'b1;
          held_rd    = out_rd_o;
          held_wdata = out_wdata_o;
          held_we    = out_rf_we_o;
          held_bch   = out_bch_taken_o;
        end
        idle_cnt++;
        if (idle_cnt > TIMEOUT) begin
          errors++;
          timeout_hit = 1'b1;
          $display("Timeout: no output record accepted within %0d cycles", TIMEOUT);
        end
      end
    end
    collect_done = 1'b1;
  endtask

  task automatic run_phase(input int phase);
    drive_done   = 1'b0;
    collect_done = 1'b0;
    stall_en     = (phase != 0);
    fork
      drive_all();
      collect_records(phase);
      drive_out_ready();
    join
    out_ready_i = 1'b1;
    // A leftover record could only come from a killed row
    repeat (2) @(negedge clk);
    check_value("out_valid_o idle", 32'(out_valid_o), 32'd0);
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    errors       = 0;
    checks       = 0;
    timeout_hit  = 1'b0;
    drive_done   = 1'b0;
    collect_done = 1'b0;
    stall_en     = 1'b0;
    void'($urandom(32'h218b_e0c0));
    $readmemh("verif/ex_patterns.hex", pat_mem);
    rst_n       = 1'b0;
    out_ready_i = 1'b1;
    idle_inputs();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("out_valid_o after reset", 32'(out_valid_o), 32'd0);
    @(posedge clk);
    #1;
    run_phase(0);
    if (!timeout_hit) begin
      run_phase(1);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timeout_hit) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verif/ex_patterns.hex */
// unit oper op_a op_b rd rf_we kill exp_wdata exp_bch
// unit 0 is the ALU and 1 the multiplier; a row with kill set expects no record
0 0 7fffffff 00000001 01 1 0 80000000 0
0 1 00000005 00000007 02 1 0 fffffffe 0
0 2 f0f0ff00 0ff0f0f0 03 1 0 00f0f000 0
0 3 f0f0ff00 0ff0f0f0 04 1 0 fff0fff0 0
0 4 f0f0ff00 0ff0f0f0 05 1 0 ff000ff0 0
0 5 80000001 00000004 06 1 0 00000010 0
0 6 80000000 0000001f 07 1 0 00000001 0
0 7 80000010 00000024 08 1 0 f8000001 0
0 8 ffffffff 00000001 09 1 0 00000001 0
0 9 ffffffff 00000001 0a 1 0 00000000 0
0 a 12345678 12345678 00 1 0 00000000 1
0 b 12345678 12345678 00 1 0 00000000 0
0 c 80000000 7fffffff 00 1 0 00000000 1
0 d 80000000 7fffffff 00 1 0 00000000 0
0 e 80000000 7fffffff 00 1 0 00000000 0
0 f 80000000 7fffffff 00 1 0 00000000 1
1 0 fffffffd 00000007 0b 1 0 ffffffeb 0
1 1 80000000 80000000 0c 1 0 40000000 0
1 1 80000000 00000002 0d 1 0 ffffffff 0
1 2 ffffffff ffffffff 0e 1 0 ffffffff 0
1 3 ffffffff ffffffff 0f 1 0 fffffffe 0
0 0 00000010 00000020 10 1 0 00000030 0
1 1 12345678 87654321 11 1 1 00000000 0
0 4 aaaaaaaa 55555555 12 1 0 ffffffff 0

/* project.f */
hdl/ex_pkg.sv
hdl/ex_mul_if.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_pipe.sv
hdl/ex_stage_top.sv
verif/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The result is taken from the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ex_stage_sim
LOG_FILE=sim.log
PASS_MSG="SIMULATION PASSED"

if ! verilator --binary --timing --assert -f project.f --top-module ex_stage_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "$PASS_MSG" "$LOG_FILE"; then
  exit 0
fi

echo "Pass line not found in $LOG_FILE"
exit 1
